// ==== tb.f ====
+incdir+verilog
verilog/tmr_pkg.sv
verilog/seu_regs.sv
verilog/tmr_voter.sv
verilog/seu_regs_file.sv
verilog/tmr_rf_top.sv
tb/tb_clock_gen.sv
tb/tb_tmr_rf.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it.
# The exit status is that of the simulation, non-zero on any failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f tb.f \
   --top-module tb_tmr_rf \
   -o tb_tmr_rf

./obj_dir/tb_tmr_rf

// ==== tb/tb_tmr_rf.sv ====
/* Testbench for the triplicated register-file write path.
   Drives write requests with replica and storage upsets, and checks reads and the
   mismatch flag against a cycle-level reference model. */

`include "tmr_config.svh"

module tb_tmr_rf import tmr_pkg::*; ();

   localparam bit see_on      = (`SEE_TESTING != 0);
   localparam int n_rand      = 64;      // Plain random writes.
   localparam int n_blk       = 8;       // Requests per upset phase.
   localparam int n_req       = 3 * `TMR_N + n_rand + 4 * n_blk + 6;
   localparam int cycle_limit = 4 * n_req + 50;

   // Expected effect of one request, two edges after it is sampled.
   typedef struct packed {
      logic  en;
      addr_t addr;
      word_t data;
      logic  mis;
   } req_t;

   logic  s_c;
   logic  arst_n;
   logic  wr_en;
   addr_t wr_addr;
   word_t wr_data;
   word_t rep_upset [3];
   logic  rf_upset_en;
   addr_t rf_upset_addr;
   word_t rf_upset_mask;
   addr_t rd_addr [`TMR_RP];
   word_t rd_data [`TMR_RP];
   logic  mismatch;

   word_t model [`TMR_N];          // Expected register-file contents.
   req_t  pipe_q [$];              // Requests in flight.
   int    cycles = 0;
   int    seed = 53769;

   tb_clock_gen #(
      .period     (100),
      .rst_cycles (2)
   ) u_clock_gen (
      .s_c_o    (s_c),
      .arst_n_o (arst_n)
   );

   tmr_rf_top uut (
      .s_c_i           (s_c),
      .arst_n_i        (arst_n),
      .wr_en_i         (wr_en),
      .wr_addr_i       (wr_addr),
      .wr_data_i       (wr_data),
      .rep_upset_i     (rep_upset),
      .rf_upset_en_i   (rf_upset_en),
      .rf_upset_addr_i (rf_upset_addr),
      .rf_upset_mask_i (rf_upset_mask),
      .rd_addr_i       (rd_addr),
      .rd_data_o       (rd_data),
      .mismatch_o      (mismatch)
   );

   function automatic word_t next_word();
      return word_t'($random(seed));
   endfunction

   function automatic addr_t next_addr();
      return addr_t'($random(seed));
   endfunction

   function automatic word_t next_mask();
      word_t r;
      r = next_word();
      return (r == '0) ? word_t'(1) : r;   // Never an empty mask.
   endfunction

   // Two-of-three vote per bit over the masked copies, and the disagreement flag.
   function automatic word_t vote_ref(input word_t d, input word_t m0, input word_t m1,
                                      input word_t m2, output logic mis);
      word_t c0;
      word_t c1;
      word_t c2;
      word_t v;
      int    ones;
      c0 = see_on ? (d ^ m0) : d;
      c1 = see_on ? (d ^ m1) : d;
      c2 = see_on ? (d ^ m2) : d;
      for (int b = 0; b < `TMR_W; b++) begin
         ones = int'(c0[b]) + int'(c1[b]) + int'(c2[b]);
         v[b] = (ones >= 2);
      end
      mis = (c0 != c1) || (c1 != c2);
      return v;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("error: %s = %h, expected %h", name, got, exp);
         $display("CHECKS FAILED");
         $fatal(1, "wrong value on %s", name);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error: %s = %h, expected %h", name, got, exp);
         $display("CHECKS FAILED");
         $fatal(1, "wrong value on %s", name);
      end
   endtask

   // One request per rising edge. The storage upset is off unless set again.
   task automatic drive_req(input logic en, input addr_t a, input word_t d,
                            input word_t m0, input word_t m1, input word_t m2);
      @(posedge s_c);
      wr_en        <= en;
      wr_addr      <= a;
      wr_data      <= d;
      rep_upset[0] <= m0;
      rep_upset[1] <= m1;
      rep_upset[2] <= m2;
      rf_upset_en  <= 1'b0;
   endtask

   task automatic storage_upset(input addr_t a, input word_t m);
      rf_upset_en   <= 1'b1;
      rf_upset_addr <= a;
      rf_upset_mask <= m;
   endtask

   task automatic set_reads(input addr_t a0, input addr_t a1);
      rd_addr[0] <= a0;
      rd_addr[1] <= a1;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         drive_req(1'b0, '0, '0, '0, '0, '0);
      end
   endtask

   // Every register is seen once on each port.
   task automatic sweep_reads();
      for (int i = 0; i < `TMR_N; i++) begin
         drive_req(1'b0, '0, '0, '0, '0, '0);
         set_reads(addr_t'(i), addr_t'(`TMR_N - 1 - i));
      end
   endtask

   // Compare at the falling edge, where inputs and outputs are settled.
   always @(negedge s_c) begin
      req_t cur;
      req_t old;
      logic mis;
      if (!arst_n) begin
         pipe_q.delete();
         for (int i = 0; i < `TMR_N; i++) begin
            model[i] = '0;
         end
      end else begin
         for (int p = 0; p < `TMR_RP; p++) begin
            check_word($sformatf("rd_data_o[%0d]", p), rd_data[p], model[rd_addr[p]]);
         end
         cur.en   = wr_en;
         cur.addr = wr_addr;
         cur.data = vote_ref(wr_data, rep_upset[0], rep_upset[1], rep_upset[2], mis);
         cur.mis  = mis;
         pipe_q.push_back(cur);
         if (pipe_q.size() == 3) begin
            old = pipe_q.pop_front();
            check_flag("mismatch_o", mismatch, old.mis);
            if (old.en) begin
               model[old.addr] = old.data;      // Lands on the next edge.
            end
         end
         // A storage upset lands on the same edge, after the write.
         if (see_on && rf_upset_en) begin
            model[rf_upset_addr] = model[rf_upset_addr] ^ rf_upset_mask;
         end
      end
   end

   always @(posedge s_c) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("CHECKS FAILED");
         $fatal(1, "timeout, run exceeded %0d cycles", cycle_limit);
      end
   end

   initial begin : stimulus
      word_t d;
      word_t m [3];
      addr_t a;
      addr_t a_d1;
      addr_t a_d2;
      int    sel;
      int    bitpos;

      wr_en         <= 1'b0;
      wr_addr       <= '0;
      wr_data       <= '0;
      rep_upset     <= '{default: '0};
      rf_upset_en   <= 1'b0;
      rf_upset_addr <= '0;
      rf_upset_mask <= '0;
      rd_addr       <= '{default: '0};
      @(posedge arst_n);

      sweep_reads();                              // All zero after reset.

      for (int i = 0; i < n_rand; i++) begin
         drive_req(1'b1, next_addr(), next_word(), '0, '0, '0);
         set_reads(next_addr(), next_addr());
      end
      sweep_reads();

      // Single replica upset, outvoted.
      for (int i = 0; i < n_blk; i++) begin
         m = '{default: '0};
         sel = int'(next_word() % 32'd3);
         m[sel] = next_mask();
         drive_req(1'b1, next_addr(), next_word(), m[0], m[1], m[2]);
         set_reads(next_addr(), next_addr());
      end

      // Same bit flipped in two replicas wins the vote.
      for (int i = 0; i < n_blk; i++) begin
         sel = int'(next_word() % 32'd3);
         bitpos = int'(next_word() % word_t'(`TMR_W));
         for (int j = 0; j < 3; j++) begin
            m[j] = (j == sel) ? '0 : (word_t'(1) << bitpos);
         end
         drive_req(1'b1, next_addr(), next_word(), m[0], m[1], m[2]);
         set_reads(next_addr(), next_addr());
      end

      // Storage upsets, each aimed at the entry written on that same edge.
      a_d1 = next_addr();
      a_d2 = next_addr();
      for (int i = 0; i < n_blk; i++) begin
         a = next_addr();
         drive_req(1'b1, a, next_word(), '0, '0, '0);
         storage_upset(a_d2, next_mask());
         set_reads(a_d2, a_d1);
         a_d2 = a_d1;
         a_d1 = a;
      end

      // Back to back writes to one address.
      a = next_addr();
      d = '0;
      for (int i = 0; i < n_blk; i++) begin
         d = next_word();
         drive_req(1'b1, a, d, '0, '0, '0);
         set_reads(a, a);
      end
      idle_cycles(3);
      @(negedge s_c);
      check_word("rd_data_o[0]", rd_data[0], d);
      check_word("rd_data_o[1]", rd_data[1], d);

      sweep_reads();
      idle_cycles(3);
      @(posedge s_c);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== tb/tb_clock_gen.sv ====
/* Clock and reset source for the register-file testbench.
   Reset is held low for the first rst_cycles clock periods. */

module tb_clock_gen #(
   parameter int period     = 100,
   parameter int rst_cycles = 2
) (
   output logic s_c_o,
   output logic arst_n_o
);

   initial begin
      s_c_o = 1'b0;
      forever #(period / 2) s_c_o = ~s_c_o;   // First rising edge at period/2.
   end

   // Release a quarter period after a falling edge, clear of both clock edges.
   initial begin
      arst_n_o = 1'b0;
      #(rst_cycles * period + period / 4);
      arst_n_o = 1'b1;
   end

endmodule

// ==== verilog/tmr_rf_top.sv ====
/* Top level of the fault-tolerant register-file write path.
   Chains replica capture, majority vote and register file; reads are combinational. */

`include "tmr_config.svh"

module tmr_rf_top import tmr_pkg::*; (
   input  logic  s_c_i,
   input  logic  arst_n_i,
   // Write request.
   input  logic  wr_en_i,
   input  addr_t wr_addr_i,
   input  word_t wr_data_i,
   // Upset injection.
   input  word_t rep_upset_i [3],
   input  logic  rf_upset_en_i,
   input  addr_t rf_upset_addr_i,
   input  word_t rf_upset_mask_i,
   // Read ports.
   input  addr_t rd_addr_i [`TMR_RP],
   output word_t rd_data_o [`TMR_RP],
   output logic  mismatch_o
);

   // Replica outputs.
   rep_t  rep_en;
   addr_t rep_addr [3];
   word_t rep_data [3];

   // Voted request.
   logic  vot_en;
   addr_t vot_addr;
   word_t vot_data;

   // Stage 1, three copies of the request.
   seu_regs u_seu_regs (
      .s_c_i      (s_c_i),
      .arst_n_i   (arst_n_i),
      .en_i       (wr_en_i),
      .addr_i     (wr_addr_i),
      .data_i     (wr_data_i),
      .upset_i    (rep_upset_i),
      .rep_en_o   (rep_en),
      .rep_addr_o (rep_addr),
      .rep_data_o (rep_data)
   );

   // Stage 2, majority vote.
   tmr_voter u_tmr_voter (
      .s_c_i      (s_c_i),
      .arst_n_i   (arst_n_i),
      .rep_en_i   (rep_en),
      .rep_addr_i (rep_addr),
      .rep_data_i (rep_data),
      .en_o       (vot_en),
      .addr_o     (vot_addr),
      .data_o     (vot_data),
      .mismatch_o (mismatch_o)
   );

   // Stage 3, storage and reads.
   seu_regs_file #(
      .rp (`TMR_RP)
   ) u_seu_regs_file (
      .s_c_i        (s_c_i),
      .arst_n_i     (arst_n_i),
      .we_i         (vot_en),
      .wadd_i       (vot_addr),
      .val_i        (vot_data),
      .upset_en_i   (rf_upset_en_i),
      .upset_addr_i (rf_upset_addr_i),
      .upset_mask_i (rf_upset_mask_i),
      .radd_i       (rd_addr_i),
      .val_o        (rd_data_o)
   );

endmodule

// ==== verilog/seu_regs_file.sv ====
/* Register file with one write port and combinational read ports.
   A storage upset can flip the bits of one entry for SEU testing. */

`include "tmr_config.svh"

module seu_regs_file import tmr_pkg::*; #(
   parameter int rp = `TMR_RP     // Number of read ports.
) (
   input  logic  s_c_i,
   input  logic  arst_n_i,
   input  logic  we_i,
   input  addr_t wadd_i,
   input  word_t val_i,
   input  logic  upset_en_i,
   input  addr_t upset_addr_i,
   input  word_t upset_mask_i,
   input  addr_t radd_i [rp],
   output word_t val_o [rp]
);

   localparam bit see_on = (`SEE_TESTING != 0);

   word_t rf_q   [`TMR_N];
   word_t rf_nxt [`TMR_N];
   logic  upset_hit;

   assign upset_hit = see_on && upset_en_i;

   // Next state of each entry. A write and an upset on the same entry combine.
   always_comb begin
      for (int i = 0; i < `TMR_N; i++) begin
         rf_nxt[i] = rf_q[i];
         if (we_i && (wadd_i == addr_t'(i))) begin
            rf_nxt[i] = val_i;
         end
         if (upset_hit && (upset_addr_i == addr_t'(i))) begin
            rf_nxt[i] = rf_nxt[i] ^ upset_mask_i;   // Flip stored bits.
         end
      end
   end

   // Storage. Every entry comes out of reset as zero.
   always_ff @(posedge s_c_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rf_q <= '{default: '0};
      end else begin
         rf_q <= rf_nxt;
      end
   end

   // Read ports see the stored array only.
   genvar p;
   generate
      for (p = 0; p < rp; p++) begin : g_rd
         assign val_o[p] = rf_q[radd_i[p]];
      end
   endgenerate

   // The voted address must be resolved whenever a write is voted in.
   property p_wadd_known;
      @(posedge s_c_i) disable iff (!arst_n_i)
         we_i |-> !$isunknown(wadd_i);
   endproperty

   a_wadd_known: assert property (p_wadd_known)
      else $error("write with unknown address");

   // Storage upset address must be resolved too.
   property p_upset_addr_known;
      @(posedge s_c_i) disable iff (!arst_n_i)
         upset_hit |-> !$isunknown(upset_addr_i);
   endproperty

   a_upset_addr_known: assert property (p_upset_addr_known)
      else $error("storage upset with unknown address");

endmodule

// ==== verilog/tmr_voter.sv ====
/* Two-of-three majority voter for the replicated write request.
   Registers the voted request and flags any disagreement between the copies. */

module tmr_voter import tmr_pkg::*; (
   input  logic  s_c_i,
   input  logic  arst_n_i,
   input  rep_t  rep_en_i,
   input  addr_t rep_addr_i [3],
   input  word_t rep_data_i [3],
   output logic  en_o,
   output addr_t addr_o,
   output word_t data_o,
   output logic  mismatch_o
);

   logic  maj_en;
   addr_t maj_addr;
   word_t maj_data;
   rep_t  rep_bad;                // Replica j disagrees with the vote.
   logic  all_eq;

   // Bitwise majority of each field.
   assign maj_en   = (rep_en_i[0] & rep_en_i[1]) |
                     (rep_en_i[0] & rep_en_i[2]) |
                     (rep_en_i[1] & rep_en_i[2]);

   assign maj_addr = (rep_addr_i[0] & rep_addr_i[1]) |
                     (rep_addr_i[0] & rep_addr_i[2]) |
                     (rep_addr_i[1] & rep_addr_i[2]);

   assign maj_data = (rep_data_i[0] & rep_data_i[1]) |
                     (rep_data_i[0] & rep_data_i[2]) |
                     (rep_data_i[1] & rep_data_i[2]);

   // If every copy equals the vote, all copies are equal.
   genvar j;
   generate
      for (j = 0; j < 3; j++) begin : g_cmp
         assign rep_bad[j] = (rep_en_i[j] != maj_en) ||
                             (rep_addr_i[j] != maj_addr) ||
                             (rep_data_i[j] != maj_data);
      end
   endgenerate

   assign all_eq = ~|rep_bad;

   // Control state.
   always_ff @(posedge s_c_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         en_o       <= 1'b0;
         mismatch_o <= 1'b0;
      end else begin
         en_o       <= maj_en;
         mismatch_o <= !all_eq;     // One cycle, tied to this request.
      end
   end

   // Payload follows the enable.
   always_ff @(posedge s_c_i) begin
      addr_o <= maj_addr;
      data_o <= maj_data;
   end

   // Equal replicas must not raise the flag on the following cycle.
   property p_no_false_flag;
      @(posedge s_c_i) disable iff (!arst_n_i)
         ((rep_en_i[0] == rep_en_i[1]) && (rep_en_i[1] == rep_en_i[2]) &&
          (rep_addr_i[0] == rep_addr_i[1]) && (rep_addr_i[1] == rep_addr_i[2]) &&
          (rep_data_i[0] == rep_data_i[1]) && (rep_data_i[1] == rep_data_i[2]))
         |=> !mismatch_o;
   endproperty

   a_no_false_flag: assert property (p_no_false_flag)
      else $error("mismatch raised for identical replicas");

endmodule

// ==== verilog/seu_regs.sv ====
/* Triplicated capture stage for a register-file write request.
   Each replica can take a data upset mask when upset testing is built in. */

`include "tmr_config.svh"

module seu_regs import tmr_pkg::*; (
   input  logic  s_c_i,
   input  logic  arst_n_i,
   input  logic  en_i,
   input  addr_t addr_i,
   input  word_t data_i,
   input  word_t upset_i [3],    // Per replica flip mask, data only.
   output rep_t  rep_en_o,
   output addr_t rep_addr_o [3],
   output word_t rep_data_o [3]
);

   localparam bit see_on = (`SEE_TESTING != 0);

   word_t wdata [3];              // Data after upset injection.

   genvar i;
   generate
      for (i = 0; i < 3; i++) begin : g_rep
         // Mask goes in before the register, so an upset lives for one request.
         assign wdata[i] = see_on ? (data_i ^ upset_i[i]) : data_i;

         always_ff @(posedge s_c_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
               rep_en_o[i]   <= 1'b0;
               rep_addr_o[i] <= '0;
               rep_data_o[i] <= '0;
            end else begin
               rep_en_o[i]   <= en_i;
               rep_addr_o[i] <= addr_i;
               rep_data_o[i] <= wdata[i];    // Independent copy.
            end
         end
      end
   endgenerate

   // Copies taken with no upset mask in force can never drift apart.
   property p_reps_equal;
      @(posedge s_c_i) disable iff (!arst_n_i)
         (!see_on || $past(~|(upset_i[0] | upset_i[1] | upset_i[2]))) |->
            ((rep_en_o[0] === rep_en_o[1]) &&
             (rep_en_o[1] === rep_en_o[2]) &&
             (rep_addr_o[0] === rep_addr_o[1]) &&
             (rep_addr_o[1] === rep_addr_o[2]) &&
             (rep_data_o[0] === rep_data_o[1]) &&
             (rep_data_o[1] === rep_data_o[2]));
   endproperty

   a_reps_equal: assert property (p_reps_equal)
      else $error("replicas differ without an upset mask");

endmodule

// ==== verilog/tmr_pkg.sv ====
/* Shared types of the triplicated write path.
   Every RTL module imports this package in its header. */

`include "tmr_config.svh"

package tmr_pkg;

   // One data word as stored in the register file.
   typedef logic [`TMR_W-1:0] word_t;

   // Register index, wide enough for TMR_N entries.
   typedef logic [$clog2(`TMR_N)-1:0] addr_t;

   // One bit per replica. Used for replica enables and disagreement flags.
   typedef logic [2:0] rep_t;

endpackage

// ==== verilog/tmr_config.svh ====
/* Build-time configuration for the triplicated register-file write path.
   Included by the package and by every module that needs a size or the upset switch. */

`ifndef TMR_CONFIG_SVH
`define TMR_CONFIG_SVH

// Width of one data word in bits.
`define TMR_W 32

// Number of registers in the register file.
`define TMR_N 32

// Number of combinational read ports.
`define TMR_RP 2

// Upset insertion for SEU testing. Set to 1 to let the replica masks and the
// storage upset port act on the design. At 0 all masks are ignored.
`define SEE_TESTING 1

`endif
